// File: hdl/cms_params.svh
// ######################################
// widths, depths and thresholds of the trace monitor
// include wherever a width or threshold is needed
// ######################################
`ifndef CMS_PARAMS_SVH
`define CMS_PARAMS_SVH

// pc and instruction widths of the monitored core
`define CMS_XLEN 32
`define CMS_INSTR_W 32

// performance events, one saturating counter each
`define CMS_N_EVENTS 4
`define CMS_EVT_CNT_W 8

// free running cycle counter, also the width of the delta field
`define CMS_CYCLE_W 32

// packet queue in front of the stream master
`define CMS_FIFO_DEPTH 8

// wfi handling
`define CMS_WFI_STOP_THRESHOLD 15
`define CMS_WFI_INSTR 32'h10500073

// control write data
`define CMS_CTRL_DATA_W 32

`endif

// File: hdl/cms_pkg.sv
// ######################################
// types shared by the trace monitor blocks
// compile before any module that imports it
// ######################################
`include "cms_params.svh"

package cms_pkg;

    // control register addresses, unlisted codes are ignored
    typedef enum logic [3:0] {
        TRIG_START_EN   = 4'd0,
        TRIG_END_EN     = 4'd1,
        TRIG_START_ADDR = 4'd2,
        TRIG_END_ADDR   = 4'd3,
        RANGE_LO_EN     = 4'd4,
        RANGE_HI_EN     = 4'd5,
        RANGE_LO        = 4'd6,
        RANGE_HI        = 4'd7
    } ctrl_addr_e;

    // trigger and range configuration, 132 bits
    typedef struct packed {
        logic                  trig_start_en;
        logic                  trig_end_en;
        logic [`CMS_XLEN-1:0]  trig_start_addr;
        logic [`CMS_XLEN-1:0]  trig_end_addr;
        logic                  range_lo_en;
        logic                  range_hi_en;
        logic [`CMS_XLEN-1:0]  range_lo;
        logic [`CMS_XLEN-1:0]  range_hi;
    } trace_cfg_t;

    // the instruction that retires in the current cycle
    typedef struct packed {
        logic [`CMS_XLEN-1:0]    pc;
        logic [`CMS_INSTR_W-1:0] instr;
    } retire_t;

    // event 0 sits in the most significant slot
    typedef logic [0:`CMS_N_EVENTS-1][`CMS_EVT_CNT_W-1:0] evt_counts_t;

    // one trace packet, 128 bits, instr at the top
    typedef struct packed {
        logic [`CMS_INSTR_W-1:0] instr;
        logic [`CMS_CYCLE_W-1:0] cycle_delta;
        logic [`CMS_XLEN-1:0]    pc;
        evt_counts_t             evt_counts;
    } trace_pkt_t;

endpackage

// File: hdl/ctrl_regs.sv
// ######################################
// control register block of the trace monitor
// writes are taken on the rising edge of ctrl_we
// ######################################
`timescale 1ns/100ps
`include "cms_params.svh"

module ctrl_regs
    import cms_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  ctrl_addr_e                  ctrl_addr,
    input  logic [`CMS_CTRL_DATA_W-1:0] ctrl_wdata,
    input  logic                        ctrl_we,
    output trace_cfg_t                  cfg
);

    // previous sample of the write strobe
    logic we_q;
    logic we_rise;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= ctrl_we;
        end
    end

    // high only in the first cycle the strobe is seen high
    assign we_rise = ctrl_we & ~we_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // all filters off, range open on both sides
            cfg.trig_start_en   <= 1'b0;
            cfg.trig_end_en     <= 1'b0;
            cfg.trig_start_addr <= '0;
            cfg.trig_end_addr   <= '0;
            cfg.range_lo_en     <= 1'b0;
            cfg.range_hi_en     <= 1'b0;
            cfg.range_lo        <= '0;
            cfg.range_hi        <= '1;
        end else if (we_rise) begin
            case (ctrl_addr)
                // enables take bit 0 only
                TRIG_START_EN: begin
                    cfg.trig_start_en <= ctrl_wdata[0];
                end
                TRIG_END_EN: begin
                    cfg.trig_end_en <= ctrl_wdata[0];
                end
                // trigger addresses must match the pc exactly
                TRIG_START_ADDR: begin
                    cfg.trig_start_addr <= ctrl_wdata[`CMS_XLEN-1:0];
                end
                TRIG_END_ADDR: begin
                    cfg.trig_end_addr <= ctrl_wdata[`CMS_XLEN-1:0];
                end
                RANGE_LO_EN: begin
                    cfg.range_lo_en <= ctrl_wdata[0];
                end
                RANGE_HI_EN: begin
                    cfg.range_hi_en <= ctrl_wdata[0];
                end
                // inclusive bounds of the monitored range
                RANGE_LO: begin
                    cfg.range_lo <= ctrl_wdata[`CMS_XLEN-1:0];
                end
                RANGE_HI: begin
                    cfg.range_hi <= ctrl_wdata[`CMS_XLEN-1:0];
                end
                default: begin
                    // unknown address, write dropped
                end
            endcase
        end
    end

endmodule

// File: hdl/retire_tracker.sv
// ######################################
// pc/instr sampling and retirement detection
// also stops tracing after a long run of wfi
// ######################################
`timescale 1ns/100ps
`include "cms_params.svh"

module retire_tracker
    import cms_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CMS_XLEN-1:0]    pc,
    input  logic [`CMS_INSTR_W-1:0] instr,
    input  logic                    en,
    output retire_t                 retired,
    output logic                    retire,
    output logic                    wfi_stopped
);

    localparam int WFI_CNT_W = $clog2(`CMS_WFI_STOP_THRESHOLD + 1);
    localparam logic [WFI_CNT_W-1:0] WFI_MAX = WFI_CNT_W'(`CMS_WFI_STOP_THRESHOLD);

    // stage 0 is the raw sample, stage 1 the instruction being retired
    logic [`CMS_XLEN-1:0]    s0_pc;
    logic [`CMS_INSTR_W-1:0] s0_instr;
    logic [`CMS_XLEN-1:0]    s1_pc;
    logic [`CMS_INSTR_W-1:0] s1_instr;
    logic [WFI_CNT_W-1:0]    wfi_cnt;
    logic                    s1_is_wfi;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s0_pc    <= '0;
            s0_instr <= '0;
            s1_pc    <= '0;
            s1_instr <= '0;
        end else begin
            s0_pc    <= pc;
            s0_instr <= instr;
            s1_pc    <= s0_pc;
            s1_instr <= s0_instr;
        end
    end

    assign s1_is_wfi = (s1_instr == `CMS_WFI_INSTR);

    // counts cycles spent on wfi, saturates at the threshold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wfi_cnt <= '0;
        end else if (!s1_is_wfi) begin
            wfi_cnt <= '0;
        end else if (en && wfi_cnt < WFI_MAX) begin
            wfi_cnt <= wfi_cnt + 1'b1;
        end
    end

    assign wfi_stopped = (wfi_cnt == WFI_MAX);

    // stage 1 retires when a new pc shows up behind it
    // a held wfi also retires once, just before tracing stops
    always_comb begin
        retire = ((s0_pc != s1_pc) || (wfi_cnt == WFI_MAX - 1'b1))
                 && (s1_pc != '0);
    end

    assign retired.pc    = s1_pc;
    assign retired.instr = s1_instr;

endmodule

// File: hdl/trace_gate.sv
// ######################################
// decides which retired instructions are traced
// from start/end triggers and the monitored range
// ######################################
`timescale 1ns/100ps
`include "cms_params.svh"

module trace_gate
    import cms_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  trace_cfg_t           cfg,
    input  logic [`CMS_XLEN-1:0] pc,
    input  retire_t              retired,
    input  logic                 retire,
    input  logic                 wfi_stopped,
    input  logic                 en,
    output logic                 trace_push
);

    logic [`CMS_XLEN-1:0] pc_q;
    logic                 start_reached;
    logic                 end_reached;
    logic                 start_ok;
    logic                 end_ok;
    logic                 lo_ok;
    logic                 hi_ok;

    // incoming pc delayed one cycle, so a trigger lands between the
    // retirement of the instruction before it and its own retirement
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc;
        end
    end

    // start and end flags exclude each other, end wins a double hit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_reached <= 1'b0;
            end_reached   <= 1'b0;
        end else begin
            if (cfg.trig_start_en && pc_q == cfg.trig_start_addr) begin
                start_reached <= 1'b1;
                end_reached   <= 1'b0;
            end
            if (cfg.trig_end_en && pc_q == cfg.trig_end_addr) begin
                end_reached   <= 1'b1;
                start_reached <= 1'b0;
            end
        end
    end

    // a disabled filter always passes
    assign start_ok = start_reached | ~cfg.trig_start_en;
    assign end_ok   = ~end_reached | ~cfg.trig_end_en;
    assign lo_ok    = (retired.pc >= cfg.range_lo) | ~cfg.range_lo_en;
    assign hi_ok    = (retired.pc <= cfg.range_hi) | ~cfg.range_hi_en;

    assign trace_push = en & retire & ~wfi_stopped & start_ok & end_ok & lo_ok & hi_ok;

endmodule

// File: hdl/event_counters.sv
// ######################################
// saturating performance event counters
// restart on every traced packet
// ######################################
`timescale 1ns/100ps
`include "cms_params.svh"

module event_counters
    import cms_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CMS_N_EVENTS-1:0] perf_events,
    input  logic                     trace_push,
    output evt_counts_t              evt_counts
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            evt_counts <= '0;
        end else begin
            for (int i = 0; i < `CMS_N_EVENTS; i++) begin
                if (trace_push) begin
                    // packet takes the old count, this cycle's event starts the next one
                    evt_counts[i] <= `CMS_EVT_CNT_W'(perf_events[i]);
                end else if (perf_events[i] && evt_counts[i] != '1) begin
                    evt_counts[i] <= evt_counts[i] + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/trace_stream.sv
// ######################################
// packet assembly, packet FIFO and stream master
// drops packets on a full FIFO and flags overflow
// ######################################
`timescale 1ns/100ps
`include "cms_params.svh"

module trace_stream
    import cms_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  retire_t     retired,
    input  logic        trace_push,
    input  evt_counts_t evt_counts,
    input  logic [31:0] tlast_interval,
    input  logic        m_axis_tready,
    output logic        m_axis_tvalid,
    output trace_pkt_t  m_axis_tdata,
    output logic        m_axis_tlast,
    output logic        overflow
);

    localparam int PTR_W = $clog2(`CMS_FIFO_DEPTH);

    // packet storage, tlast kept beside each entry
    trace_pkt_t pkt_mem [`CMS_FIFO_DEPTH];
    logic       tlast_mem [`CMS_FIFO_DEPTH];

    // extra msb tells full from empty
    logic [PTR_W:0]          wr_ptr;
    logic [PTR_W:0]          rd_ptr;
    logic [`CMS_CYCLE_W-1:0] cyc_cnt;
    logic [`CMS_CYCLE_W-1:0] last_ts;
    logic [31:0]             pkt_cnt;
    logic [31:0]             pkt_cnt_nxt;
    trace_pkt_t              pkt;
    logic                    pkt_last;
    logic                    fifo_empty;
    logic                    fifo_full;
    logic                    do_wr;
    logic                    do_rd;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                        && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign do_wr      = trace_push & ~fifo_full;
    assign do_rd      = m_axis_tvalid & m_axis_tready;

    // packet of the instruction retiring now
    always_comb begin
        pkt.instr       = retired.instr;
        pkt.cycle_delta = cyc_cnt - last_ts;
        pkt.pc          = retired.pc;
        pkt.evt_counts  = evt_counts;
    end

    // tlast on every nth stored packet, interval 0 turns that off
    assign pkt_cnt_nxt = pkt_cnt + 32'd1;
    assign pkt_last    = ((tlast_interval != '0) && (pkt_cnt_nxt == tlast_interval))
                         || (retired.instr == `CMS_WFI_INSTR);

    // cycle counter and time of the last push, dropped pushes included
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc_cnt <= '0;
            last_ts <= '0;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
            if (trace_push) begin
                last_ts <= cyc_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            pkt_mem[wr_ptr[PTR_W-1:0]]   <= pkt;
            tlast_mem[wr_ptr[PTR_W-1:0]] <= pkt_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            pkt_cnt  <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr  <= wr_ptr + 1'b1;
                pkt_cnt <= pkt_last ? 32'd0 : pkt_cnt_nxt;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // sticky until reset
            if (trace_push && fifo_full) begin
                overflow <= 1'b1;
            end
        end
    end

    // head of the FIFO drives the stream, held until accepted
    assign m_axis_tvalid = ~fifo_empty;
    assign m_axis_tdata  = pkt_mem[rd_ptr[PTR_W-1:0]];
    assign m_axis_tlast  = ~fifo_empty & tlast_mem[rd_ptr[PTR_W-1:0]];

endmodule

// File: hdl/cms_top.sv
// ######################################
// top level of the continuous trace monitor
// connects sampling, gating, counters and stream
// ######################################
`timescale 1ns/100ps
`include "cms_params.svh"

module cms_top
    import cms_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CMS_XLEN-1:0]        pc,
    input  logic [`CMS_INSTR_W-1:0]     instr,
    input  ctrl_addr_e                  ctrl_addr,
    input  logic [`CMS_CTRL_DATA_W-1:0] ctrl_wdata,
    input  logic                        ctrl_we,
    input  logic                        en,
    input  logic [`CMS_N_EVENTS-1:0]    perf_events,
    input  logic [31:0]                 tlast_interval,
    output logic                        m_axis_tvalid,
    input  logic                        m_axis_tready,
    output trace_pkt_t                  m_axis_tdata,
    output logic                        m_axis_tlast,
    output logic                        overflow
);

    trace_cfg_t  cfg;
    retire_t     retired;
    logic        retire;
    logic        wfi_stopped;
    logic        trace_push;
    evt_counts_t evt_counts;

    ctrl_regs u_ctrl_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_addr  (ctrl_addr),
        .ctrl_wdata (ctrl_wdata),
        .ctrl_we    (ctrl_we),
        .cfg        (cfg)
    );

    retire_tracker u_retire_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (pc),
        .instr       (instr),
        .en          (en),
        .retired     (retired),
        .retire      (retire),
        .wfi_stopped (wfi_stopped)
    );

    // raw pc feeds the trigger match
    trace_gate u_trace_gate (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .pc          (pc),
        .retired     (retired),
        .retire      (retire),
        .wfi_stopped (wfi_stopped),
        .en          (en),
        .trace_push  (trace_push)
    );

    event_counters u_event_counters (
        .clk         (clk),
        .rst_n       (rst_n),
        .perf_events (perf_events),
        .trace_push  (trace_push),
        .evt_counts  (evt_counts)
    );

    trace_stream u_trace_stream (
        .clk            (clk),
        .rst_n          (rst_n),
        .retired        (retired),
        .trace_push     (trace_push),
        .evt_counts     (evt_counts),
        .tlast_interval (tlast_interval),
        .m_axis_tready  (m_axis_tready),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tlast   (m_axis_tlast),
        .overflow       (overflow)
    );

endmodule

// File: tests/cms_chk.sv
// ######################################
// stream protocol assertions of the trace monitor
// bound into cms_top from the testbench
// ######################################
`timescale 1ns/100ps
`include "cms_params.svh"

module cms_chk
    import cms_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       m_axis_tvalid,
    input logic       m_axis_tready,
    input trace_pkt_t m_axis_tdata,
    input logic       m_axis_tlast,
    input logic       overflow
);

    // a stalled beat keeps its payload
    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
        else $error("stalled beat changed");

    // no beat in reset or in the first cycle after it
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !m_axis_tvalid)
        else $error("tvalid high around reset");

    tlast_valid: assert property (@(posedge clk) disable iff (!rst_n)
        m_axis_tlast |-> m_axis_tvalid)
        else $error("tlast without tvalid");

    // overflow is sticky
    overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        overflow |=> overflow)
        else $error("overflow fell without reset");

endmodule

// File: tests/cms_tb.sv
// ######################################
// testbench for the trace monitor top level
// random pc stream against a cycle model of the monitor
// ######################################
`timescale 1ns/100ps
`include "cms_params.svh"

module cms_tb
    import cms_pkg::*;
();

    // upper bound of the stimulus length in cycles for the watchdog
    localparam int TOTAL_CYCLES = 1600;
    localparam int WFI_TH = `CMS_WFI_STOP_THRESHOLD;
    localparam int EVT_FLAT_W = `CMS_N_EVENTS * `CMS_EVT_CNT_W;

    logic                        clk;
    logic                        rst_n;
    logic [`CMS_XLEN-1:0]        pc;
    logic [`CMS_INSTR_W-1:0]     instr;
    ctrl_addr_e                  ctrl_addr;
    logic [`CMS_CTRL_DATA_W-1:0] ctrl_wdata;
    logic                        ctrl_we;
    logic                        en;
    logic [`CMS_N_EVENTS-1:0]    perf_events;
    logic [31:0]                 tlast_interval;
    logic                        m_axis_tvalid;
    logic                        m_axis_tready;
    trace_pkt_t                  m_axis_tdata;
    logic                        m_axis_tlast;
    logic                        overflow;

    // stimulus modes
    logic        ready_random;
    logic        ready_level;
    logic        evt_force;
    logic [31:0] lfsr_state = 32'hf9fb430a;

    // cycle model of the monitor
    logic [31:0]      m_s0_pc, m_s0_instr, m_s1_pc, m_s1_instr, m_pc_q;
    logic [31:0]      m_cyc, m_ts, m_pcnt;
    logic [7:0]       m_evt [`CMS_N_EVENTS];
    int               m_wfi;
    logic             m_start, m_end, m_we_q, m_ovf;
    logic             retire_m, push_m, full_m, last_m;
    logic [EVT_FLAT_W-1:0] evt_flat;
    trace_cfg_t       m_cfg;
    trace_pkt_t       pkt_m;
    trace_pkt_t       head;
    logic             head_last;
    trace_pkt_t       exp_q [$];
    logic             exp_last_q [$];

    cms_top uut (.*);

    bind cms_top cms_chk u_chk (.*);

    always #5 clk = ~clk;

    // 32 bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        assert (got === exp) else begin
            $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // one cycle of stimulus applied on the falling edge
    task automatic drive_cycle(input logic [31:0] p, input logic [31:0] i);
        @(negedge clk);
        pc            = p;
        instr         = i;
        perf_events   = evt_force ? '1 : `CMS_N_EVENTS'(rand_bits(`CMS_N_EVENTS));
        m_axis_tready = ready_random ? lfsr_bit() : ready_level;
    endtask

    task automatic hold_pc(input logic [31:0] p, input logic [31:0] i, input int cycles);
        repeat (cycles) drive_cycle(p, i);
    endtask

    // n pc changes in a 1 KiB window above base held 1 to 4 cycles each
    task automatic run_seq(input int n, input logic [31:0] base);
        logic [31:0] p;
        int          hold;
        for (int k = 0; k < n; k++) begin
            p = base + (rand_bits(8) << 2);
            if (p == pc) begin
                p = p + 32'd4;
            end
            hold = 1 + int'(rand_bits(2));
            hold_pc(p, rand_bits(32), hold);
        end
    endtask

    task automatic write_ctrl(input ctrl_addr_e a, input logic [31:0] d);
        @(negedge clk);
        ctrl_addr  = a;
        ctrl_wdata = d;
        ctrl_we    = 1'b1;
        @(negedge clk);
        ctrl_we = 1'b0;
    endtask

    // model step where all reads see the values from before the edge
    always @(posedge clk) begin
        if (!rst_n) begin
            {m_s0_pc, m_s0_instr, m_s1_pc, m_s1_instr, m_pc_q} = '0;
            {m_cyc, m_ts, m_pcnt} = '0;
            {m_start, m_end, m_we_q, m_ovf} = '0;
            m_wfi = 0;
            m_cfg = '0;
            m_cfg.range_hi = '1;
            for (int i = 0; i < `CMS_N_EVENTS; i++) begin
                m_evt[i] = '0;
            end
            exp_q.delete();
            exp_last_q.delete();
        end else begin
            retire_m = ((m_s0_pc != m_s1_pc) || (m_wfi == WFI_TH - 1)) && (m_s1_pc != 0);
            push_m = en && retire_m && (m_wfi != WFI_TH)
                     && (m_start || !m_cfg.trig_start_en)
                     && (!m_end || !m_cfg.trig_end_en)
                     && (m_s1_pc >= m_cfg.range_lo || !m_cfg.range_lo_en)
                     && (m_s1_pc <= m_cfg.range_hi || !m_cfg.range_hi_en);
            full_m = (exp_q.size() == `CMS_FIFO_DEPTH);
            check_val("m_axis_tvalid", 128'(m_axis_tvalid), 128'(exp_q.size() != 0));
            check_val("overflow", 128'(overflow), 128'(m_ovf));
            // output beat against the oldest expected packet
            if (m_axis_tvalid && m_axis_tready) begin
                head      = exp_q.pop_front();
                head_last = exp_last_q.pop_front();
                check_val("tdata.instr", 128'(m_axis_tdata.instr), 128'(head.instr));
                check_val("tdata.cycle_delta", 128'(m_axis_tdata.cycle_delta),
                          128'(head.cycle_delta));
                check_val("tdata.pc", 128'(m_axis_tdata.pc), 128'(head.pc));
                check_val("tdata.evt_counts", 128'(m_axis_tdata.evt_counts),
                          128'(head.evt_counts));
                check_val("m_axis_tlast", 128'(m_axis_tlast), 128'(head_last));
            end
            if (push_m) begin
                if (full_m) begin
                    m_ovf = 1'b1;
                end else begin
                    pkt_m.instr       = m_s1_instr;
                    pkt_m.cycle_delta = m_cyc - m_ts;
                    pkt_m.pc          = m_s1_pc;
                    // counters shifted in from the bottom leave event 0 in the top slot
                    evt_flat = '0;
                    for (int i = 0; i < `CMS_N_EVENTS; i++) begin
                        evt_flat = (evt_flat << `CMS_EVT_CNT_W) | EVT_FLAT_W'(m_evt[i]);
                    end
                    pkt_m.evt_counts = evt_flat;
                    last_m = ((tlast_interval != 0) && (m_pcnt + 32'd1 == tlast_interval))
                             || (m_s1_instr == `CMS_WFI_INSTR);
                    m_pcnt = last_m ? 32'd0 : m_pcnt + 32'd1;
                    exp_q.push_back(pkt_m);
                    exp_last_q.push_back(last_m);
                end
                m_ts = m_cyc;
            end
            // event counts restart with this cycle's bits on a push
            for (int i = 0; i < `CMS_N_EVENTS; i++) begin
                if (push_m) begin
                    m_evt[i] = {7'd0, perf_events[i]};
                end else if (perf_events[i] && m_evt[i] != 8'hff) begin
                    m_evt[i] = m_evt[i] + 8'd1;
                end
            end
            if (m_cfg.trig_start_en && m_pc_q == m_cfg.trig_start_addr) begin
                m_start = 1'b1;
                m_end   = 1'b0;
            end
            if (m_cfg.trig_end_en && m_pc_q == m_cfg.trig_end_addr) begin
                m_end   = 1'b1;
                m_start = 1'b0;
            end
            if (m_s1_instr != `CMS_WFI_INSTR) begin
                m_wfi = 0;
            end else if (en && m_wfi < WFI_TH) begin
                m_wfi = m_wfi + 1;
            end
            m_pc_q     = pc;
            m_s1_pc    = m_s0_pc;
            m_s1_instr = m_s0_instr;
            m_s0_pc    = pc;
            m_s0_instr = instr;
            // config changes only on a rising write strobe
            if (ctrl_we && !m_we_q) begin
                case (ctrl_addr)
                    TRIG_START_EN: m_cfg.trig_start_en = ctrl_wdata[0];
                    TRIG_END_EN: m_cfg.trig_end_en = ctrl_wdata[0];
                    TRIG_START_ADDR: m_cfg.trig_start_addr = ctrl_wdata;
                    TRIG_END_ADDR: m_cfg.trig_end_addr = ctrl_wdata;
                    RANGE_LO_EN: m_cfg.range_lo_en = ctrl_wdata[0];
                    RANGE_HI_EN: m_cfg.range_hi_en = ctrl_wdata[0];
                    RANGE_LO: m_cfg.range_lo = ctrl_wdata;
                    RANGE_HI: m_cfg.range_hi = ctrl_wdata;
                    default: ;
                endcase
            end
            m_we_q = ctrl_we;
            m_cyc  = m_cyc + 32'd1;
        end
    end

    initial begin
        #(TOTAL_CYCLES * 20.0 + 2000.0);
        $display("Timeout, the run did not finish in time");
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        pc             = '0;
        instr          = '0;
        ctrl_addr      = TRIG_START_EN;
        ctrl_wdata     = '0;
        ctrl_we        = 1'b0;
        en             = 1'b1;
        perf_events    = '0;
        tlast_interval = 32'd3;
        m_axis_tready  = 1'b1;
        ready_random   = 1'b0;
        ready_level    = 1'b1;
        evt_force      = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // open filters trace every retirement
        run_seq(40, 32'h1000);
        // inclusive range 0x1100..0x1200
        write_ctrl(RANGE_LO, 32'h1100);
        write_ctrl(RANGE_HI, 32'h1200);
        write_ctrl(RANGE_LO_EN, 32'd1);
        write_ctrl(RANGE_HI_EN, 32'd1);
        run_seq(60, 32'h1000);
        // both bounds and the pcs just outside them
        hold_pc(32'h10fc, rand_bits(32), 2);
        hold_pc(32'h1100, rand_bits(32), 2);
        hold_pc(32'h1200, rand_bits(32), 2);
        hold_pc(32'h1204, rand_bits(32), 2);
        hold_pc(32'h1000, rand_bits(32), 2);
        write_ctrl(RANGE_LO_EN, 32'd0);
        write_ctrl(RANGE_HI_EN, 32'd0);
        // start at 0x1040 and stop at 0x1080
        write_ctrl(TRIG_START_ADDR, 32'h1040);
        write_ctrl(TRIG_END_ADDR, 32'h1080);
        write_ctrl(TRIG_START_EN, 32'd1);
        write_ctrl(TRIG_END_EN, 32'd1);
        run_seq(10, 32'h2400);
        hold_pc(32'h1040, rand_bits(32), 2);
        run_seq(10, 32'h2400);
        hold_pc(32'h1080, rand_bits(32), 2);
        run_seq(10, 32'h2400);
        write_ctrl(TRIG_START_EN, 32'd0);
        write_ctrl(TRIG_END_EN, 32'd0);
        // long gap saturates the event counters
        evt_force = 1'b1;
        hold_pc(32'h3000, rand_bits(32), 300);
        evt_force = 1'b0;
        // held wfi stops tracing until a new pc arrives
        tlast_interval = 32'd5;
        hold_pc(32'h2000, `CMS_WFI_INSTR, 30);
        run_seq(20, 32'h1000);
        // random back-pressure
        ready_random = 1'b1;
        run_seq(40, 32'h1000);
        // stalled sink overfills the FIFO
        ready_random = 1'b0;
        ready_level  = 1'b0;
        run_seq(14, 32'h1000);
        ready_level = 1'b1;
        run_seq(6, 32'h1000);
        while (exp_q.size() != 0) begin
            drive_cycle(pc, instr);
        end
        // idle cycles with nothing left to send
        repeat (4) drive_cycle(pc, instr);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: all.f
+incdir+hdl
hdl/cms_pkg.sv
hdl/ctrl_regs.sv
hdl/retire_tracker.sv
hdl/trace_gate.sv
hdl/event_counters.sv
hdl/trace_stream.sv
hdl/cms_top.sv
tests/cms_chk.sv
tests/cms_tb.sv

// File: run.sh
#!/bin/sh
# build and run the trace monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module cms_tb -o cms_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/cms_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation finished: PASS" "$LOG"; then
    if [ $run_status -ne 0 ]; then
        echo "simulator returned status $run_status"
        exit 1
    fi
    echo "run passed"
    exit 0
fi

echo "run failed"
exit 1
